/* rtl/refill_pkg.sv */
package refill_pkg;

    // byte address on the refill bus
    typedef logic [31:0] addr_t;

    // one Wishbone data word
    typedef logic [31:0] word_t;

    // carried unchanged from miss request to response
    typedef logic [3:0] txn_id_t;

    // access size of a data miss
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // arbiter grant state
    // data and fetch states also mean the bus cycle is open
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_DATA  = 2'd1,
        ARB_FETCH = 2'd2
    } arb_state_t;

endpackage

/* rtl/ifetch_miss_port.sv */
module ifetch_miss_port #(
    parameter int LINE_WORDS = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               miss_valid,
    output logic                               miss_ready,
    input  refill_pkg::addr_t                  miss_addr,
    input  refill_pkg::txn_id_t                miss_id,
    output logic                               resp_valid,
    output refill_pkg::txn_id_t                resp_id,
    output refill_pkg::word_t [LINE_WORDS-1:0] resp_line,
    output logic                               req,
    output refill_pkg::addr_t                  req_addr,
    input  logic                               beat_valid,
    input  refill_pkg::word_t                  beat_data,
    input  logic                               done
);

    localparam int CNT_W = $clog2(LINE_WORDS);
    // byte offset bits inside one line
    localparam int OFS_W = CNT_W + 2;
    localparam refill_pkg::addr_t LINE_MASK = ~refill_pkg::addr_t'((1 << OFS_W) - 1);

    logic                               pending;
    logic                               accept;
    logic [CNT_W-1:0]                   beat_cnt;
    refill_pkg::addr_t                  addr_q;
    refill_pkg::txn_id_t                id_q;
    refill_pkg::word_t [LINE_WORDS-1:0] line_q;

    assign accept = miss_valid & miss_ready;

    // one miss at a time
    assign miss_ready = !pending;
    assign req        = pending;
    assign req_addr   = addr_q;
    assign resp_id    = id_q;
    assign resp_line  = line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            resp_valid <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            resp_valid <= 1'b0;
            if (accept) begin
                pending  <= 1'b1;
                beat_cnt <= '0;
            end else if (beat_valid) begin
                beat_cnt <= beat_cnt + CNT_W'(1);
            end
            // final beat drops the request and responds next cycle
            if (done) begin
                pending    <= 1'b0;
                resp_valid <= 1'b1;
            end
        end
    end

    // request fields and line buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= miss_addr & LINE_MASK;
            id_q   <= miss_id;
        end
        // beats arrive in address order from the line base
        if (beat_valid) begin
            line_q[beat_cnt] <= beat_data;
        end
    end

endmodule

/* rtl/dmem_miss_port.sv */
module dmem_miss_port (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                miss_valid,
    output logic                miss_ready,
    input  refill_pkg::addr_t   miss_addr,
    input  refill_pkg::size_t   miss_size,
    input  refill_pkg::txn_id_t miss_id,
    output logic                resp_valid,
    output refill_pkg::txn_id_t resp_id,
    output refill_pkg::word_t   resp_data,
    output logic                req,
    output refill_pkg::addr_t   req_addr,
    input  logic                beat_valid,
    input  refill_pkg::word_t   beat_data,
    input  logic                done
);

    logic                pending;
    logic                accept;
    refill_pkg::addr_t   addr_q;
    logic [1:0]          ofs_q;
    refill_pkg::size_t   size_q;
    refill_pkg::txn_id_t id_q;
    refill_pkg::word_t   shifted;
    refill_pkg::word_t   lane_data;

    assign accept = miss_valid & miss_ready;

    assign miss_ready = !pending;
    assign req        = pending;
    assign req_addr   = addr_q;
    assign resp_id    = id_q;

    // move the addressed byte lane down to bit 0
    // bytes beyond the word boundary are simply lost
    always_comb begin
        shifted = beat_data >> {ofs_q, 3'b000};
        case (size_q)
            refill_pkg::SIZE_BYTE: lane_data = {24'd0, shifted[7:0]};
            refill_pkg::SIZE_HALF: lane_data = {16'd0, shifted[15:0]};
            default:               lane_data = shifted;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (accept) begin
                pending <= 1'b1;
            end
            // done comes with the single beat
            if (done) begin
                pending    <= 1'b0;
                resp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // word aligned for the bus and offset kept for extraction
            addr_q <= {miss_addr[31:2], 2'b00};
            ofs_q  <= miss_addr[1:0];
            size_q <= miss_size;
            id_q   <= miss_id;
        end
        if (beat_valid) begin
            resp_data <= lane_data;
        end
    end

endmodule

/* rtl/refill_arbiter.sv */
module refill_arbiter #(
    parameter int LINE_WORDS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_req,
    input  refill_pkg::addr_t fetch_addr,
    input  logic              data_req,
    input  refill_pkg::addr_t data_addr,
    output logic              fetch_beat_valid,
    output logic              fetch_done,
    output logic              data_beat_valid,
    output logic              data_done,
    output refill_pkg::word_t beat_data,
    output logic              wb_cyc,
    output logic              wb_stb,
    output refill_pkg::addr_t wb_adr,
    input  refill_pkg::word_t wb_dat_i,
    input  logic              wb_ack
);

    localparam int CNT_W = $clog2(LINE_WORDS);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(LINE_WORDS - 1);

    refill_pkg::arb_state_t state;
    refill_pkg::arb_state_t state_nxt;
    logic [CNT_W-1:0]       beat_cnt;
    refill_pkg::addr_t      adr_q;
    logic                   grant_data;
    logic                   grant_fetch;
    logic                   beat_ack;
    logic                   last_beat;

    assign grant_data  = (state == refill_pkg::ARB_DATA);
    assign grant_fetch = (state == refill_pkg::ARB_FETCH);

    // cyc and stb held for the whole grant
    assign wb_cyc = grant_data | grant_fetch;
    assign wb_stb = wb_cyc;
    assign wb_adr = adr_q;

    assign beat_ack = wb_stb & wb_ack;

    // data is always a single beat
    assign last_beat = grant_data | (beat_cnt == LAST_CNT);

    // only the granted port sees the returned beat
    assign beat_data        = wb_dat_i;
    assign data_beat_valid  = grant_data & beat_ack;
    assign data_done        = data_beat_valid & last_beat;
    assign fetch_beat_valid = grant_fetch & beat_ack;
    assign fetch_done       = fetch_beat_valid & last_beat;

    always_comb begin
        state_nxt = state;
        case (state)
            refill_pkg::ARB_IDLE: begin
                // data first when both wait
                if (data_req) begin
                    state_nxt = refill_pkg::ARB_DATA;
                end else if (fetch_req) begin
                    state_nxt = refill_pkg::ARB_FETCH;
                end
            end
            refill_pkg::ARB_DATA,
            refill_pkg::ARB_FETCH: begin
                if (beat_ack && last_beat) begin
                    state_nxt = refill_pkg::ARB_IDLE;
                end
            end
            default: begin
                state_nxt = refill_pkg::ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= refill_pkg::ARB_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == refill_pkg::ARB_IDLE) begin
                beat_cnt <= '0;
            end else if (beat_ack) begin
                beat_cnt <= beat_cnt + CNT_W'(1);
            end
        end
    end

    // bus address loaded at grant and stepped one word per ack
    always_ff @(posedge clk) begin
        if (state == refill_pkg::ARB_IDLE) begin
            if (data_req) begin
                adr_q <= data_addr;
            end else if (fetch_req) begin
                adr_q <= fetch_addr;
            end
        end else if (beat_ack) begin
            adr_q <= adr_q + 32'd4;
        end
    end

endmodule

/* rtl/refill_top.sv */
module refill_top #(
    parameter int LINE_WORDS = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // instruction line misses
    input  logic                               if_miss_valid,
    output logic                               if_miss_ready,
    input  refill_pkg::addr_t                  if_miss_addr,
    input  refill_pkg::txn_id_t                if_miss_id,
    output logic                               if_resp_valid,
    output refill_pkg::txn_id_t                if_resp_id,
    output refill_pkg::word_t [LINE_WORDS-1:0] if_resp_line,
    // data word misses
    input  logic                               dm_miss_valid,
    output logic                               dm_miss_ready,
    input  refill_pkg::addr_t                  dm_miss_addr,
    input  refill_pkg::size_t                  dm_miss_size,
    input  refill_pkg::txn_id_t                dm_miss_id,
    output logic                               dm_resp_valid,
    output refill_pkg::txn_id_t                dm_resp_id,
    output refill_pkg::word_t                  dm_resp_data,
    // shared Wishbone read master
    output logic                               wb_cyc,
    output logic                               wb_stb,
    output refill_pkg::addr_t                  wb_adr,
    input  refill_pkg::word_t                  wb_dat_i,
    input  logic                               wb_ack
);

    logic              if_req;
    refill_pkg::addr_t if_req_addr;
    logic              if_beat_valid;
    logic              if_done;
    logic              dm_req;
    refill_pkg::addr_t dm_req_addr;
    logic              dm_beat_valid;
    logic              dm_done;
    refill_pkg::word_t beat_data;

    ifetch_miss_port #(
        .LINE_WORDS(LINE_WORDS)
    ) u_ifetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss_valid (if_miss_valid),
        .miss_ready (if_miss_ready),
        .miss_addr  (if_miss_addr),
        .miss_id    (if_miss_id),
        .resp_valid (if_resp_valid),
        .resp_id    (if_resp_id),
        .resp_line  (if_resp_line),
        .req        (if_req),
        .req_addr   (if_req_addr),
        .beat_valid (if_beat_valid),
        .beat_data  (beat_data),
        .done       (if_done)
    );

    dmem_miss_port u_dmem (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss_valid (dm_miss_valid),
        .miss_ready (dm_miss_ready),
        .miss_addr  (dm_miss_addr),
        .miss_size  (dm_miss_size),
        .miss_id    (dm_miss_id),
        .resp_valid (dm_resp_valid),
        .resp_id    (dm_resp_id),
        .resp_data  (dm_resp_data),
        .req        (dm_req),
        .req_addr   (dm_req_addr),
        .beat_valid (dm_beat_valid),
        .beat_data  (beat_data),
        .done       (dm_done)
    );

    refill_arbiter #(
        .LINE_WORDS(LINE_WORDS)
    ) u_arb (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_req        (if_req),
        .fetch_addr       (if_req_addr),
        .data_req         (dm_req),
        .data_addr        (dm_req_addr),
        .fetch_beat_valid (if_beat_valid),
        .fetch_done       (if_done),
        .data_beat_valid  (dm_beat_valid),
        .data_done        (dm_done),
        .beat_data        (beat_data),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_adr           (wb_adr),
        .wb_dat_i         (wb_dat_i),
        .wb_ack           (wb_ack)
    );

endmodule

/* verification/refill_sva.sv */
module refill_sva (
    input logic                   clk,
    input logic                   rst_n,
    input refill_pkg::arb_state_t state,
    input logic                   fetch_req,
    input logic                   data_req,
    input logic                   wb_cyc,
    input logic                   wb_stb,
    input refill_pkg::addr_t      wb_adr,
    input logic                   wb_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // cycle closes only right after an acked beat
    cyc_close: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(wb_cyc) |-> $past(wb_stb && wb_ack))
        else $error("wb_cyc dropped without an acked beat");

    // address held until the slave acks
    adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else $error("wb_adr changed during a stalled beat");

    // data port wins when both wait in idle
    data_first: assert property (@(posedge clk) disable iff (!rst_n)
        (state == refill_pkg::ARB_IDLE && data_req && fetch_req)
        |=> (state == refill_pkg::ARB_DATA))
        else $error("fetch granted ahead of a waiting data request");

endmodule

bind refill_arbiter refill_sva sva0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .fetch_req (fetch_req),
    .data_req  (data_req),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_ack    (wb_ack)
);

/* verification/refill_tb.sv */
module refill_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_WORDS = 4;
    localparam int ITERATIONS = 300;
    localparam int TIMEOUT_CYCLES = ITERATIONS * (LINE_WORDS * 4 + 16) * 2;
    localparam refill_pkg::addr_t LINE_MASK = refill_pkg::addr_t'(LINE_WORDS * 4 - 1);

    logic                               clk = 1'b0;
    logic                               rst_n;
    logic                               if_miss_valid;
    logic                               if_miss_ready;
    refill_pkg::addr_t                  if_miss_addr;
    refill_pkg::txn_id_t                if_miss_id;
    logic                               if_resp_valid;
    refill_pkg::txn_id_t                if_resp_id;
    refill_pkg::word_t [LINE_WORDS-1:0] if_resp_line;
    logic                               dm_miss_valid;
    logic                               dm_miss_ready;
    refill_pkg::addr_t                  dm_miss_addr;
    refill_pkg::size_t                  dm_miss_size;
    refill_pkg::txn_id_t                dm_miss_id;
    logic                               dm_resp_valid;
    refill_pkg::txn_id_t                dm_resp_id;
    refill_pkg::word_t                  dm_resp_data;
    logic                               wb_cyc;
    logic                               wb_stb;
    refill_pkg::addr_t                  wb_adr;
    refill_pkg::word_t                  wb_dat_i = '0;
    logic                               wb_ack = 1'b0;

    // reference model with one entry per outstanding miss
    refill_pkg::txn_id_t fetch_id_q[$];
    refill_pkg::addr_t   fetch_base_q[$];
    refill_pkg::txn_id_t data_id_q[$];
    refill_pkg::addr_t   data_addr_q[$];
    refill_pkg::size_t   data_size_q[$];

    // acked addresses of the open bus cycle
    refill_pkg::addr_t beat_addrs[$];

    int  ack_wait = -1;
    int  cycle_cnt = 0;
    bit  in_cycle = 1'b0;
    bit  if_resp_seen = 1'b0;
    bit  dm_resp_seen = 1'b0;
    // stage 1 expects the data cycle next and stage 2 the fetch line
    int  prio_stage = 0;
    refill_pkg::addr_t prio_data_adr;
    refill_pkg::addr_t prio_fetch_adr;

    refill_top #(
        .LINE_WORDS(LINE_WORDS)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .if_miss_valid (if_miss_valid),
        .if_miss_ready (if_miss_ready),
        .if_miss_addr  (if_miss_addr),
        .if_miss_id    (if_miss_id),
        .if_resp_valid (if_resp_valid),
        .if_resp_id    (if_resp_id),
        .if_resp_line  (if_resp_line),
        .dm_miss_valid (dm_miss_valid),
        .dm_miss_ready (dm_miss_ready),
        .dm_miss_addr  (dm_miss_addr),
        .dm_miss_size  (dm_miss_size),
        .dm_miss_id    (dm_miss_id),
        .dm_resp_valid (dm_resp_valid),
        .dm_resp_id    (dm_resp_id),
        .dm_resp_data  (dm_resp_data),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .wb_dat_i      (wb_dat_i),
        .wb_ack        (wb_ack)
    );

    always #10 clk = ~clk;

    // memory contents are the word address rotated left by 7 and xored
    function automatic refill_pkg::word_t mem_word(input refill_pkg::addr_t a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a_1234;
    endfunction

    // addressed lanes of the word zero extended to the access size
    function automatic refill_pkg::word_t data_expect(input refill_pkg::addr_t a,
                                                       input refill_pkg::size_t size);
        refill_pkg::word_t w;
        w = mem_word({a[31:2], 2'b00}) >> (8 * int'(a[1:0]));
        if (size == refill_pkg::SIZE_BYTE) begin
            return w & 32'h0000_00ff;
        end
        if (size == refill_pkg::SIZE_HALF) begin
            return w & 32'h0000_ffff;
        end
        return w;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_reset_state();
        check_value("reset wb_cyc", 32'd0, 32'(wb_cyc));
        check_value("reset wb_stb", 32'd0, 32'(wb_stb));
        check_value("reset if_resp_valid", 32'd0, 32'(if_resp_valid));
        check_value("reset dm_resp_valid", 32'd0, 32'(dm_resp_valid));
        check_value("reset if_miss_ready", 32'd1, 32'(if_miss_ready));
        check_value("reset dm_miss_ready", 32'd1, 32'(dm_miss_ready));
    endtask

    task automatic issue_fetch();
        refill_pkg::addr_t a;
        refill_pkg::txn_id_t id;
        a = refill_pkg::addr_t'($urandom());
        id = refill_pkg::txn_id_t'($urandom());
        if_miss_valid = 1'b1;
        if_miss_addr = a;
        if_miss_id = id;
        fetch_id_q.push_back(id);
        fetch_base_q.push_back(a & ~LINE_MASK);
    endtask

    task automatic issue_data();
        refill_pkg::addr_t a;
        refill_pkg::txn_id_t id;
        refill_pkg::size_t size;
        a = refill_pkg::addr_t'($urandom());
        id = refill_pkg::txn_id_t'($urandom());
        size = refill_pkg::size_t'($urandom_range(0, 2));
        dm_miss_valid = 1'b1;
        dm_miss_addr = a;
        dm_miss_size = size;
        dm_miss_id = id;
        data_id_q.push_back(id);
        data_addr_q.push_back(a);
        data_size_q.push_back(size);
    endtask

    // one beat means a data refill and more means a line burst
    task automatic check_bus_cycle();
        if (beat_addrs.size() == 1) begin
            if (data_id_q.size() == 0) begin
                abort_run("single beat bus cycle with no data miss outstanding");
            end
            check_value("data bus address", {data_addr_q[0][31:2], 2'b00}, beat_addrs[0]);
        end else begin
            if (fetch_id_q.size() == 0) begin
                abort_run("burst bus cycle with no fetch miss outstanding");
            end
            check_value("burst length", 32'(LINE_WORDS), 32'(beat_addrs.size()));
            for (int k = 0; k < LINE_WORDS; k++) begin
                check_value($sformatf("burst address %0d", k),
                            fetch_base_q[0] + refill_pkg::addr_t'(4 * k), beat_addrs[k]);
            end
        end
    endtask

    task automatic watch_responses();
        if (if_resp_valid) begin
            if (if_resp_seen) begin
                abort_run("fetch response pulse lasted more than one cycle");
            end
            if (fetch_id_q.size() == 0) begin
                abort_run("fetch response with no outstanding fetch miss");
            end
            check_value("fetch ready with response", 32'd1, 32'(if_miss_ready));
            check_value("fetch response id", 32'(fetch_id_q[0]), 32'(if_resp_id));
            for (int k = 0; k < LINE_WORDS; k++) begin
                check_value($sformatf("fetch line word %0d", k),
                            mem_word(fetch_base_q[0] + refill_pkg::addr_t'(4 * k)),
                            if_resp_line[k]);
            end
            void'(fetch_id_q.pop_front());
            void'(fetch_base_q.pop_front());
        end
        if (dm_resp_valid) begin
            if (dm_resp_seen) begin
                abort_run("data response pulse lasted more than one cycle");
            end
            if (data_id_q.size() == 0) begin
                abort_run("data response with no outstanding data miss");
            end
            check_value("data ready with response", 32'd1, 32'(dm_miss_ready));
            check_value("data response id", 32'(data_id_q[0]), 32'(dm_resp_id));
            check_value("data response value", data_expect(data_addr_q[0], data_size_q[0]),
                        dm_resp_data);
            void'(data_id_q.pop_front());
            void'(data_addr_q.pop_front());
            void'(data_size_q.pop_front());
        end
        if_resp_seen = if_resp_valid;
        dm_resp_seen = dm_resp_valid;
    endtask

    // Wishbone slave acks after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            ack_wait = -1;
        end else if (wb_ack) begin
            // beat completed on the rising edge just past
            wb_ack <= 1'b0;
            ack_wait = -1;
        end else if (wb_stb) begin
            if (ack_wait < 0) begin
                ack_wait = int'($urandom_range(0, 3));
            end
            if (ack_wait == 0) begin
                wb_ack <= 1'b1;
                wb_dat_i <= mem_word(wb_adr);
                beat_addrs.push_back(wb_adr);
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    // bus cycle tracking and response checks
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_cyc && !in_cycle) begin
                in_cycle = 1'b1;
                if (prio_stage == 1) begin
                    check_value("priority data first", prio_data_adr, wb_adr);
                    prio_stage = 2;
                end else if (prio_stage == 2) begin
                    check_value("priority fetch second", prio_fetch_adr, wb_adr);
                    prio_stage = 0;
                end
            end else if (!wb_cyc && in_cycle) begin
                in_cycle = 1'b0;
                check_bus_cycle();
                beat_addrs.delete();
            end
            watch_responses();
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the run hung before all refills completed");
        end
    end

    initial begin
        int  kind;
        int  gap;
        bit  do_fetch;
        bit  do_data;
        rst_n = 1'b0;
        if_miss_valid = 1'b0;
        if_miss_addr = '0;
        if_miss_id = '0;
        dm_miss_valid = 1'b0;
        dm_miss_addr = '0;
        dm_miss_size = refill_pkg::SIZE_WORD;
        dm_miss_id = '0;
        void'($urandom(32'h7f3a_6c48));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state();
        for (int i = 0; i < ITERATIONS; i++) begin
            kind = int'($urandom_range(0, 2));
            do_fetch = (kind != 1);
            do_data = (kind != 0);
            while ((do_fetch && !if_miss_ready) || (do_data && !dm_miss_ready)) begin
                @(negedge clk);
            end
            if (do_fetch) begin
                issue_fetch();
            end
            if (do_data) begin
                issue_data();
            end
            // both accepted on one edge so the data cycle must come first
            if (do_fetch && do_data) begin
                prio_data_adr = {data_addr_q[$][31:2], 2'b00};
                prio_fetch_adr = fetch_base_q[$];
                prio_stage = 1;
            end
            @(negedge clk);
            if_miss_valid = 1'b0;
            dm_miss_valid = 1'b0;
            gap = int'($urandom_range(0, 2));
            repeat (gap) @(negedge clk);
        end
        while (fetch_id_q.size() != 0 || data_id_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (fetch_id_q.size() == 0 && data_id_q.size() == 0 && !wb_cyc) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("refills still outstanding or bus busy at end of run");
        end
    end

endmodule

/* compile.f */
rtl/refill_pkg.sv
rtl/ifetch_miss_port.sv
rtl/dmem_miss_port.sv
rtl/refill_arbiter.sv
rtl/refill_top.sv
verification/refill_sva.sv
verification/refill_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the refill testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f compile.f \
    --top-module refill_tb \
    -Mdir obj_dir \
    -o refill_sim &&
./obj_dir/refill_sim ||
{ echo "simulation returned a failing status"; exit 1; }
